// File: filter_bench.f
+incdir+src
src/filter_pkg.sv
src/sample_delay.sv
src/exp_sig_gen.sv
src/boxcar_filter.sv
src/diff_filter.sv
src/filter.sv
testbench/filter_checker.sv
testbench/filter_sva.sv
testbench/filter_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the filter bench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module filter_tb -f filter_bench.f -o filter_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Raise the error limit so assertion errors do not stop the run early
./obj_dir/filter_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: testbench/filter_tb.sv
// Filter bench testbench driving the test controls from a table of rows
`default_nettype none

`include "filter_params.svh"

module filter_tb;

	localparam int NROWS = 12;

	logic                     clk;
	logic                     reset;
	logic                     test_overlay;
	logic                     test_rate;
	logic [`DELAY_WIDTH-1:0]  test_delay;
	filter_pkg::adc_t         output_data;
	filter_pkg::sum_t         output_data_avg;
	filter_pkg::diff_t        output_data_diff;

	// --------------------
	// Stimulus table
	// --------------------
	logic                     row_reset [NROWS];
	logic                     row_overlay [NROWS];
	logic                     row_rate [NROWS];
	logic [`DELAY_WIDTH-1:0]  row_delay [NROWS];
	int                       row_cycles [NROWS];

	int   error_count;
	int   check_count;
	int   timeout_count = 0;
	int   cycle_count = 0;
	int   cycle_limit = 0;
	logic limit_ready = 1'b0;

	filter i_filter (
		.clk              (clk),
		.reset            (reset),
		.test_overlay     (test_overlay),
		.test_rate        (test_rate),
		.test_delay       (test_delay),
		.output_data      (output_data),
		.output_data_avg  (output_data_avg),
		.output_data_diff (output_data_diff)
	);

	filter_checker i_checker (
		.clk              (clk),
		.reset            (reset),
		.overlay          (test_overlay),
		.rate             (test_rate),
		.delay            (test_delay),
		.output_data      (output_data),
		.output_data_avg  (output_data_avg),
		.output_data_diff (output_data_diff),
		.error_count      (error_count),
		.check_count      (check_count)
	);

	initial begin : clock_gen
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic add_row(input int idx, input int rst, input int ovl, input int rt,
		input int dly, input int cyc);
		row_reset[idx] = (rst != 0);
		row_overlay[idx] = (ovl != 0);
		row_rate[idx] = (rt != 0);
		row_delay[idx] = dly[`DELAY_WIDTH-1:0];
		row_cycles[idx] = cyc;
	endtask

	task automatic build_table();
		int rt;
		int dly;
		int ovl;
		// Single pulse at the slow rate over two full periods
		add_row(0, 1, 0, 0, 10, 600);
		// Switch to the fast rate mid-period
		add_row(1, 0, 0, 1, 10, 200);
		// Delay beyond the fast period so no pulse starts
		add_row(2, 1, 0, 1, 100, 150);
		// Row ends mid-decay and the next one resets into it
		add_row(3, 1, 0, 0, 40, 60);
		add_row(4, 1, 0, 0, 40, 120);
		// Delay follows the counter for back to back pulses into saturation
		add_row(5, 1, 1, 1, 0, 1);
		add_row(6, 0, 1, 1, 1, 1);
		add_row(7, 0, 1, 1, 2, 1);
		add_row(8, 0, 1, 1, 3, 200);
		// Random rows where a fast delay may run past the period
		for (int i = 9; i < NROWS; i++) begin
			rt = $urandom % 2;
			dly = (rt != 0) ? $urandom % 96 : $urandom % 256;
			ovl = $urandom % 2;
			add_row(i, 1, ovl, rt, dly, 300);
		end
	endtask

	// Two reset cycles before a flagged row
	task automatic apply_row(input int idx);
		test_overlay <= row_overlay[idx];
		test_rate <= row_rate[idx];
		test_delay <= row_delay[idx];
		if (row_reset[idx]) begin
			reset <= 1'b1;
			repeat (2) @(posedge clk);
			reset <= 1'b0;
		end
		repeat (row_cycles[idx]) @(posedge clk);
	endtask

	task automatic report_counts();
		$display("Errors: %0d compare of %0d, %0d assertion, %0d timeout",
			error_count, check_count, i_filter.i_filter_sva.fail_count, timeout_count);
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin : main
		int total;
		reset <= 1'b1;
		test_overlay <= 1'b0;
		test_rate <= 1'b0;
		test_delay <= '0;
		void'($urandom(32'h5df3a2f1));
		build_table();
		// Row cycles plus two reset cycles per row plus margin
		cycle_limit = 20;
		for (int i = 0; i < NROWS; i++)
			cycle_limit += row_cycles[i] + 2;
		limit_ready = 1'b1;
		@(posedge clk);
		for (int i = 0; i < NROWS; i++)
			apply_row(i);
		// Last compare and assertion settle
		repeat (2) @(posedge clk);
		@(negedge clk);
		#1;
		total = error_count + i_filter.i_filter_sva.fail_count;
		if (check_count == 0) begin
			$display("No compares were made, the checker never saw a reset");
			total++;
		end
		report_counts();
		if (total == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Cycle counter watchdog
	initial begin : watchdog
		wait (limit_ready);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Run timed out after %0d cycles before the stimulus table finished",
			cycle_count);
		timeout_count++;
		report_counts();
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/filter_sva.sv
// Filter top level assertions on the reset state and the pulse amplitude bound
`default_nettype none

`include "filter_params.svh"

module filter_sva (
	input wire                clk,
	input wire                reset,
	input wire                test_overlay,
	input filter_pkg::adc_t   output_data,
	input filter_pkg::sum_t   output_data_avg,
	input filter_pkg::diff_t  output_data_diff
);

	// Overlay seen since the last reset
	logic overlay_used;
	int   fail_count = 0;

	always @(posedge clk) begin
		if (reset)
			overlay_used <= 1'b0;
		else if (test_overlay)
			overlay_used <= 1'b1;
	end

	// --------------------
	// Properties
	// --------------------
	reset_clears: assert property (@(posedge clk)
		$fell(reset) |->
			(output_data == '0 && output_data_avg == '0 && output_data_diff == '0))
		else begin
			$error("outputs not zero in the first cycle after reset");
			fail_count++;
		end

	// Without pile-up a pulse never rises above its start height
	amplitude_bound: assert property (@(posedge clk) disable iff (reset)
		!overlay_used |-> int'(output_data) <= `AMPLITUDE)
		else begin
			$error("output_data above the pulse amplitude without overlay");
			fail_count++;
		end

endmodule

bind filter filter_sva i_filter_sva (
	.clk              (clk),
	.reset            (reset),
	.test_overlay     (test_overlay),
	.output_data      (output_data),
	.output_data_avg  (output_data_avg),
	.output_data_diff (output_data_diff)
);

`default_nettype wire

// File: testbench/filter_checker.sv
// Cycle model of the filter pipeline comparing all three DUT outputs every cycle
`default_nettype none

`include "filter_params.svh"

module filter_checker (
	input  wire                     clk,
	input  wire                     reset,
	input  wire                     overlay,
	input  wire                     rate,
	input  wire [`DELAY_WIDTH-1:0]  delay,
	input  filter_pkg::adc_t        output_data,
	input  filter_pkg::sum_t        output_data_avg,
	input  filter_pkg::diff_t       output_data_diff,
	output int                      error_count,
	output int                      check_count
);

	// --------------------
	// Model constants
	// --------------------
	localparam int ADC_TOP = (1 << `ADC_WIDTH) - 1;
	localparam int AMP = `AMPLITUDE;
	localparam int LAST_SLOW = `PERIOD_SLOW - 1;
	localparam int LAST_FAST = `PERIOD_FAST - 1;

	// Expected DUT state after the last edge
	int   m_cnt;
	int   m_sig;
	int   m_avg;
	int   m_diff;
	// Input history, newest at index 0
	int   sig_hist [`BOXCAR_DEPTH];
	int   avg_hist [`DIFF_DEPTH+1];
	// Set once the first reset was seen
	logic armed = 1'b0;
	int   errors = 0;
	int   checks = 0;

	assign error_count = errors;
	assign check_count = checks;

	// --------------------
	// Model step
	// --------------------
	// Inputs read here still hold their pre-edge values
	always @(posedge clk) begin : model_step
		int next_sig;
		int next_avg;
		int last;
		if (reset) begin
			m_cnt = 0;
			m_sig = 0;
			m_avg = 0;
			m_diff = 0;
			for (int i = 0; i < `BOXCAR_DEPTH; i++)
				sig_hist[i] = 0;
			for (int i = 0; i <= `DIFF_DEPTH; i++)
				avg_hist[i] = 0;
			armed = 1'b1;
		end else begin
			// Window of the current and previous samples
			for (int i = `BOXCAR_DEPTH - 1; i > 0; i--)
				sig_hist[i] = sig_hist[i-1];
			sig_hist[0] = m_sig;
			next_avg = 0;
			for (int i = 0; i < `BOXCAR_DEPTH; i++)
				next_avg += sig_hist[i];
			// Current sum minus the sum DIFF_DEPTH inputs back
			for (int i = `DIFF_DEPTH; i > 0; i--)
				avg_hist[i] = avg_hist[i-1];
			avg_hist[0] = m_avg;
			m_diff = avg_hist[0] - avg_hist[`DIFF_DEPTH];
			// Pulse start or decay
			if (m_cnt == int'(delay)) begin
				if (overlay)
					next_sig = (m_sig + AMP > ADC_TOP) ? ADC_TOP : m_sig + AMP;
				else
					next_sig = AMP;
			end else begin
				next_sig = m_sig - (m_sig >> `DECAY_SHIFT);
			end
			// Counter left past the end by a rate switch restarts too
			last = rate ? LAST_FAST : LAST_SLOW;
			m_cnt = (m_cnt >= last) ? 0 : m_cnt + 1;
			m_sig = next_sig;
			m_avg = next_avg;
		end
	end

	task automatic compare(input string name, input int expected, input int observed);
		checks++;
		if (expected != observed) begin
			errors++;
			$display("FAILED t=%0t %s expected %0d observed %0d",
				$time, name, expected, observed);
		end
	endtask

	// --------------------
	// Compare
	// --------------------
	// Mid-cycle, outputs settled
	always @(negedge clk) begin
		if (armed && !reset) begin
			compare("output_data", m_sig, int'(output_data));
			compare("output_data_avg", m_avg, int'(output_data_avg));
			compare("output_data_diff", m_diff, int'(output_data_diff));
		end
	end

endmodule

`default_nettype wire

// File: src/filter.sv
// Filter bench top level chaining the pulse generator, boxcar and differentiator
`default_nettype none

`include "filter_params.svh"

module filter (
	input  wire                     clk,
	input  wire                     reset,
	// --------------------
	// Test controls
	// --------------------
	input  wire                     test_overlay,
	input  wire                     test_rate,
	input  wire [`DELAY_WIDTH-1:0]  test_delay,
	// --------------------
	// Stage outputs
	// --------------------
	// Raw test signal
	output filter_pkg::adc_t        output_data,
	// Boxcar sum, one cycle behind output_data
	output filter_pkg::sum_t        output_data_avg,
	// Difference, two cycles behind output_data
	output filter_pkg::diff_t       output_data_diff
);

	// Stage to stage samples, one per clock
	filter_pkg::adc_t  sig_data;
	filter_pkg::sum_t  avg_data;

	// Taps exposed at the top
	assign output_data     = sig_data;
	assign output_data_avg = avg_data;

	// --------------------
	// Pipeline
	// --------------------
	exp_sig_gen i_exp_sig_gen (
		.clk         (clk),
		.reset       (reset),
		.overlay     (test_overlay),
		.rate        (test_rate),
		.delay       (test_delay),
		.output_data (sig_data)
	);

	// Running sum of the test signal
	boxcar_filter i_boxcar_filter (
		.clk         (clk),
		.reset       (reset),
		.input_data  (sig_data),
		.output_data (avg_data)
	);

	// Shapes the running sum
	diff_filter i_diff_filter (
		.clk         (clk),
		.reset       (reset),
		.input_data  (avg_data),
		.output_data (output_data_diff)
	);

endmodule

`default_nettype wire

// File: src/diff_filter.sv
// Differentiator stage subtracting the sum from DIFF_DEPTH samples earlier
`default_nettype none

`include "filter_params.svh"

module diff_filter (
	input  wire               clk,
	input  wire               reset,
	input  filter_pkg::sum_t  input_data,
	output filter_pkg::diff_t output_data
);

	// --------------------
	// Signals
	// --------------------
	// Sum from DIFF_DEPTH inputs ago
	filter_pkg::sum_t   old_sum;
	// Signed copies with a zero sign bit
	filter_pkg::diff_t  cur_ext;
	filter_pkg::diff_t  old_ext;
	filter_pkg::diff_t  diff_reg;

	// Lag line on the sums
	sample_delay #(
		.payload_t (filter_pkg::sum_t),
		.DEPTH     (`DIFF_DEPTH)
	) i_lag_delay (
		.clk      (clk),
		.reset    (reset),
		.in_data  (input_data),
		.out_data (old_sum)
	);

	// --------------------
	// Difference
	// --------------------
	assign cur_ext = $signed({1'b0, input_data});
	assign old_ext = $signed({1'b0, old_sum});

	// Boxcar step becomes a flat-topped bipolar shape
	// Negative while the sum falls during decay
	always_ff @(posedge clk) begin
		if (reset) begin
			diff_reg <= '0;
		end else begin
			diff_reg <= cur_ext - old_ext;
		end
	end

	assign output_data = diff_reg;

endmodule

`default_nettype wire

// File: src/boxcar_filter.sv
// Boxcar stage forming the running sum of the last BOXCAR_DEPTH samples
`default_nettype none

`include "filter_params.svh"

module boxcar_filter (
	input  wire               clk,
	input  wire               reset,
	input  filter_pkg::adc_t  input_data,
	output filter_pkg::sum_t  output_data
);

	// --------------------
	// Signals
	// --------------------
	// Sample leaving the window, BOXCAR_DEPTH inputs old
	filter_pkg::adc_t  old_data;
	// Running window sum
	filter_pkg::sum_t  acc;
	filter_pkg::sum_t  acc_next;
	// Both operands widened to the sum width
	filter_pkg::sum_t  new_ext;
	filter_pkg::sum_t  old_ext;

	// --------------------
	// Window delay line
	// --------------------
	// Zero after reset, so the early window fills with zeros
	sample_delay #(
		.payload_t (filter_pkg::adc_t),
		.DEPTH     (`BOXCAR_DEPTH)
	) i_window_delay (
		.clk      (clk),
		.reset    (reset),
		.in_data  (input_data),
		.out_data (old_data)
	);

	// --------------------
	// Accumulator
	// --------------------
	assign new_ext = filter_pkg::sum_t'(input_data);
	assign old_ext = filter_pkg::sum_t'(old_data);

	// Add the entering sample, drop the leaving one
	// Intermediate wrap cancels, the true sum always fits in sum_t
	assign acc_next = acc + new_ext - old_ext;

	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
		end else begin
			acc <= acc_next;
		end
	end

	// One cycle latency
	assign output_data = acc;

endmodule

`default_nettype wire

// File: src/exp_sig_gen.sv
// Test pulse generator producing periodic exponentially decaying pulses
`default_nettype none

`include "filter_params.svh"

module exp_sig_gen (
	input  wire                     clk,
	input  wire                     reset,
	// Add each pulse on top of the residual value
	input  wire                     overlay,
	// 1 selects PERIOD_FAST, 0 selects PERIOD_SLOW
	input  wire                     rate,
	// Counter value that starts a pulse
	input  wire [`DELAY_WIDTH-1:0]  delay,
	output filter_pkg::adc_t        output_data
);

	// --------------------
	// Constants
	// --------------------
	// Counter wide enough for the slow period
	localparam int CNT_WIDTH = $clog2(`PERIOD_SLOW);
	// Last counter value of each period
	localparam logic [CNT_WIDTH-1:0] LAST_SLOW = CNT_WIDTH'(`PERIOD_SLOW - 1);
	localparam logic [CNT_WIDTH-1:0] LAST_FAST = CNT_WIDTH'(`PERIOD_FAST - 1);
	// Pulse height as a sample
	localparam filter_pkg::adc_t AMP = filter_pkg::adc_t'(`AMPLITUDE);

	// --------------------
	// Signals
	// --------------------
	logic [CNT_WIDTH-1:0]  cnt;
	logic [CNT_WIDTH-1:0]  cnt_last;
	logic                  wrap;
	logic                  match;
	// Overlay sum with carry bit
	logic [`ADC_WIDTH:0]   pile_sum;
	filter_pkg::adc_t      pile_sat;
	filter_pkg::adc_t      decay_val;
	filter_pkg::adc_t      sample;
	filter_pkg::adc_t      sample_next;

	// --------------------
	// Period counter
	// --------------------
	// Rate is sampled every cycle
	assign cnt_last = rate ? LAST_FAST : LAST_SLOW;
	// Also wraps if a switch to the fast rate leaves the counter past the end
	assign wrap = (cnt >= cnt_last);

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
		end else if (wrap) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Zero-extended compare, a delay past the period never matches
	assign match = ({{`DELAY_WIDTH{1'b0}}, cnt} == {{CNT_WIDTH{1'b0}}, delay});

	// --------------------
	// Pulse value
	// --------------------
	// Pile-up on the current output, clamped at full scale
	assign pile_sum = {1'b0, sample} + {1'b0, AMP};
	assign pile_sat = pile_sum[`ADC_WIDTH] ? filter_pkg::ADC_MAX : pile_sum[`ADC_WIDTH-1:0];

	// Shift and subtract, no multiplier
	// Never underflows since the shifted value is at most the value itself
	assign decay_val = sample - (sample >> `DECAY_SHIFT);

	always_comb begin
		if (!match) begin
			sample_next = decay_val;
		end else if (overlay) begin
			sample_next = pile_sat;
		end else begin
			// Fresh pulse, residual dropped
			sample_next = AMP;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sample <= '0;
		end else begin
			sample <= sample_next;
		end
	end

	// Registered output, match in cycle n shows after the closing edge
	assign output_data = sample;

endmodule

`default_nettype wire

// File: src/sample_delay.sv
// Fixed-depth shift-register delay line for any payload type
`default_nettype none

module sample_delay #(
	// Payload carried through the line
	parameter type payload_t = logic,
	// Number of register stages
	parameter int DEPTH = 1
) (
	input  wire      clk,
	input  wire      reset,
	input  payload_t in_data,
	output payload_t out_data
);

	// --------------------
	// Storage
	// --------------------
	// Stage 0 takes the new sample, stage DEPTH-1 is the oldest
	payload_t taps [DEPTH];

	// --------------------
	// Shift register
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			// Whole line cleared so samples before reset count as zero
			for (int i = 0; i < DEPTH; i++) begin
				taps[i] <= '0;
			end
		end else begin
			taps[0] <= in_data;
			// Move every entry one stage older
			for (int i = 1; i < DEPTH; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

	// Sample from DEPTH edges ago
	assign out_data = taps[DEPTH-1];

endmodule

`default_nettype wire

// File: src/filter_pkg.sv
// Filter bench package with the sample, running sum and difference types
`default_nettype none

`include "filter_params.svh"

package filter_pkg;

	// --------------------
	// Data types
	// --------------------
	// Raw ADC sample, unsigned
	typedef logic [`ADC_WIDTH-1:0] adc_t;

	// Running sum over the boxcar window
	// Grows by BOXCAR_LOG2 bits so a full window of ADC_MAX fits
	typedef logic [`ADC_WIDTH+`BOXCAR_LOG2-1:0] sum_t;

	// Signed difference of two sums
	// One extra bit for the sign
	typedef logic signed [`ADC_WIDTH+`BOXCAR_LOG2:0] diff_t;

	// --------------------
	// Constants
	// --------------------
	// Saturation limit of the generator, all ones
	localparam adc_t ADC_MAX = '1;

endpackage

`default_nettype wire

// File: src/filter_params.svh
// Filter bench parameters for sample widths, pulse timing and filter lengths
`ifndef FILTER_PARAMS_SVH
`define FILTER_PARAMS_SVH

// --------------------
// Widths
// --------------------
// ADC sample width
`define ADC_WIDTH 12
// Test delay control width
`define DELAY_WIDTH 8

// --------------------
// Test pulse shape
// --------------------
// Pulse periods in clock cycles
`define PERIOD_SLOW 256
`define PERIOD_FAST 64
// Pulse height at each start
`define AMPLITUDE 2000
// Decay per cycle is value >> DECAY_SHIFT
`define DECAY_SHIFT 3

// --------------------
// Filter lengths
// --------------------
// Boxcar window, log2 and samples
`define BOXCAR_LOG2 3
`define BOXCAR_DEPTH 8
// Differentiator lag in samples
`define DIFF_DEPTH 4

`endif
